/* logic/ifu_pkg.sv */
// rv32i base encodings only with no compressed forms and no csr or system opcodes
package ifu_pkg;

    // datapath widths
    localparam int XLEN = 32;  // address and register width
    localparam int ILEN = 32;  // uncompressed instructions only

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // control transfer opcodes in inst[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b110_0011;  // beq .. bgeu
    localparam logic [6:0] OPC_JAL    = 7'b110_1111;  // pc relative jump
    localparam logic [6:0] OPC_JALR   = 7'b110_0111;  // register indirect jump

    // branch conditions in inst[14:12]
    // 3'b010 and 3'b011 are reserved and never taken
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;  // signed
    localparam logic [2:0] F3_BGE  = 3'b101;  // signed
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // addi x0, x0, 0
    // written into the decode register on a flush
    localparam logic [ILEN-1:0] INST_NOP = 32'h0000_0013;

endpackage

/* logic/sbpu.sv */
// predicts backward branches and jal as taken and never predicts jalr so fetch waits on bru
`timescale 1ns/100ps

module sbpu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [ifu_pkg::ILEN-1:0] inst_i,           // instruction from memory
    input  logic                     inst_valid_i,     // qualified fetch fire
    input  logic [ifu_pkg::XLEN-1:0] pc_i,             // pc of inst_i
    input  logic                     jalr_executed_i,  // jalr resolved in decode
    output logic                     branch_taken_o,   // take branch_addr_o next
    output logic [ifu_pkg::XLEN-1:0] branch_addr_o,    // predicted target
    output logic                     is_pred_branch_o, // cond branch predicted taken
    output logic                     wait_for_jalr_o   // fetch blocked until jalr resolves
);
    import ifu_pkg::*;

    logic [6:0]      opcode;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] j_imm;
    logic            pred_branch;
    logic            pred_jal;
    logic            wait_q;

    // opcode decode for the three control types
    assign opcode    = inst_i[6:0];
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);
    assign is_jalr   = (opcode == OPC_JALR);

    // b-type immediate with bit 0 always zero
    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    // j-type immediate
    assign j_imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // backward taken, forward not taken
    assign pred_branch = inst_valid_i & is_branch & b_imm[XLEN-1];
    assign pred_jal    = inst_valid_i & is_jal;   // jal target is known so always taken

    assign branch_taken_o   = pred_branch | pred_jal;
    assign is_pred_branch_o = pred_branch;        // travels with the inst into decode

    // one target adder shared by branch and jal
    assign branch_addr_o = pc_i + (is_branch ? b_imm : j_imm);

    // jalr wait flag
    // jalr needs rs1 which is only read in decode
    // set one cycle after the jalr fires, cleared one cycle after bru resolves it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_q <= 1'b0;
        end else if (inst_valid_i && is_jalr) begin
            wait_q <= 1'b1;
        end else if (jalr_executed_i) begin
            wait_q <= 1'b0;
        end
    end

    assign wait_for_jalr_o = wait_q;

endmodule

/* logic/pc_gen.sv */
// fetch answer must arrive in the same cycle as the request and a redirect drops that answer
`timescale 1ns/100ps

module pc_gen (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_valid_i,   // memory answer valid
    input  logic                     stall_i,        // freeze fetch
    input  logic                     wait_jalr_i,    // jalr pending in sbpu
    input  logic                     pred_taken_i,   // static prediction
    input  logic [ifu_pkg::XLEN-1:0] pred_addr_i,
    input  logic                     redirect_i,     // correction from bru
    input  logic [ifu_pkg::XLEN-1:0] redirect_pc_i,
    output logic [ifu_pkg::XLEN-1:0] pc_o,           // fetch address
    output logic                     fetch_req_o,
    output logic                     fetch_fire_o    // only qualified valid downstream
);
    import ifu_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            req;
    logic            fire;

    // no request while frozen or while waiting on a jalr target
    assign req = ~wait_jalr_i & ~stall_i;

    // answer accepted only while requested
    // wrong-path answer in a redirect cycle is dropped here
    assign fire = inst_valid_i & req & ~redirect_i;

    // next pc in priority order
    always_comb begin
        if (redirect_i) begin
            pc_next = redirect_pc_i;           // bru correction
        end else if (stall_i || !fire) begin
            pc_next = pc_q;                    // nothing taken this cycle
        end else if (pred_taken_i) begin
            pc_next = pred_addr_i;             // predicted target
        end else begin
            pc_next = pc_q + XLEN'(4);         // sequential
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o         = pc_q;
    assign fetch_req_o  = req;
    assign fetch_fire_o = fire;

endmodule

/* logic/if_id_reg.sv */
// single entry decode register where flush beats capture and stall holds every field
`timescale 1ns/100ps

module if_id_reg (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fire_i,   // fetch accepted this cycle
    input  logic                     stall_i,  // hold contents
    input  logic                     flush_i,  // redirect from bru
    input  logic [ifu_pkg::ILEN-1:0] inst_i,
    input  logic [ifu_pkg::XLEN-1:0] pc_i,
    input  logic                     pred_i,   // predicted taken flag
    output logic [ifu_pkg::ILEN-1:0] inst_o,
    output logic [ifu_pkg::XLEN-1:0] pc_o,
    output logic                     pred_o,
    output logic                     valid_o
);
    import ifu_pkg::*;

    logic            valid_q;
    logic [ILEN-1:0] inst_q;
    logic [XLEN-1:0] pc_q;
    logic            pred_q;

    // valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;           // wrong path gone
        end else if (!stall_i) begin
            valid_q <= fire_i;         // empty bubble when nothing fired
        end
    end

    // payload only meaningful while valid_q is set
    always_ff @(posedge clk) begin
        if (flush_i) begin
            inst_q <= INST_NOP;
            pred_q <= 1'b0;
        end else if (!stall_i && fire_i) begin
            inst_q <= inst_i;
            pc_q   <= pc_i;
            pred_q <= pred_i;
        end
    end

    assign inst_o  = inst_q;
    assign pc_o    = pc_q;
    assign pred_o  = pred_q;
    assign valid_o = valid_q;

endmodule

/* logic/bru.sv */
// resolves only conditional branches and jalr in decode where operands come from outside
`timescale 1ns/100ps

module bru (
    input  logic [ifu_pkg::ILEN-1:0] inst_i,         // instruction in decode
    input  logic [ifu_pkg::XLEN-1:0] pc_i,
    input  logic                     pred_i,         // static taken flag
    input  logic                     valid_i,
    input  logic                     stall_i,        // no resolution while frozen
    input  logic [ifu_pkg::XLEN-1:0] rs1_i,
    input  logic [ifu_pkg::XLEN-1:0] rs2_i,
    output logic                     redirect_o,
    output logic [ifu_pkg::XLEN-1:0] redirect_pc_o,
    output logic                     jalr_done_o     // releases the sbpu wait
);
    import ifu_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            active;
    logic            is_branch;
    logic            is_jalr;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] i_imm;
    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic            mispredict;
    logic [XLEN-1:0] branch_target;
    logic [XLEN-1:0] jalr_sum;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];

    // resolve only a live, unfrozen instruction
    assign active    = valid_i & ~stall_i;
    assign is_branch = active & (opcode == OPC_BRANCH);
    assign is_jalr   = active & (opcode == OPC_JALR);   // jal was fully handled in fetch

    assign b_imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign i_imm = {{20{inst_i[31]}}, inst_i[31:20]};

    // comparators shared by all six conditions
    assign eq   = (rs1_i == rs2_i);
    assign lt_s = ($signed(rs1_i) < $signed(rs2_i));
    assign lt_u = (rs1_i < rs2_i);

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = ~eq;
            F3_BLT:  taken = lt_s;
            F3_BGE:  taken = ~lt_s;
            F3_BLTU: taken = lt_u;
            F3_BGEU: taken = ~lt_u;
            default: taken = 1'b0;               // reserved encodings fall through
        endcase
    end

    // actual outcome against static guess
    assign mispredict = is_branch & (taken != pred_i);

    // correct path for the branch
    assign branch_target = taken ? (pc_i + b_imm) : (pc_i + XLEN'(4));

    // jalr target with the lsb cleared
    assign jalr_sum = rs1_i + i_imm;

    always_comb begin
        redirect_pc_o = branch_target;
        if (is_jalr) begin
            redirect_pc_o = {jalr_sum[XLEN-1:1], 1'b0};
        end
    end

    // jalr is never predicted so it always redirects
    assign redirect_o  = mispredict | is_jalr;
    assign jalr_done_o = is_jalr;

endmodule

/* logic/ifu_top.sv */
// fetch front end only and the instruction memory must answer combinationally on fetch_pc_o
`timescale 1ns/100ps

module ifu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // fetch side
    output logic [ifu_pkg::XLEN-1:0] fetch_pc_o,
    output logic                     fetch_req_o,
    input  logic [ifu_pkg::ILEN-1:0] inst_i,
    input  logic                     inst_valid_i,   // only seen while fetch_req_o is high
    input  logic                     stall_i,        // freezes fetch and decode
    // operands for the instruction in decode
    input  logic [ifu_pkg::XLEN-1:0] rs1_i,
    input  logic [ifu_pkg::XLEN-1:0] rs2_i,
    // decode stage
    output logic [ifu_pkg::ILEN-1:0] id_inst_o,
    output logic [ifu_pkg::XLEN-1:0] id_pc_o,
    output logic                     id_valid_o,
    // fetch correction
    output logic                     redirect_o,
    output logic [ifu_pkg::XLEN-1:0] redirect_pc_o
);
    import ifu_pkg::*;

    logic [XLEN-1:0] pc;             // current fetch pc
    logic            fetch_fire;     // accepted fetch
    logic            branch_taken;
    logic [XLEN-1:0] branch_addr;
    logic            is_pred_branch;
    logic            wait_for_jalr;
    logic            id_pred;        // prediction flag in decode
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            jalr_done;

    pc_gen u_pc_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_valid_i  (inst_valid_i),
        .stall_i       (stall_i),
        .wait_jalr_i   (wait_for_jalr),
        .pred_taken_i  (branch_taken),
        .pred_addr_i   (branch_addr),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .pc_o          (pc),
        .fetch_req_o   (fetch_req_o),
        .fetch_fire_o  (fetch_fire)
    );

    // predictor sees the instruction only when fetch fired
    sbpu u_sbpu (
        .clk              (clk),
        .rst_n            (rst_n),
        .inst_i           (inst_i),
        .inst_valid_i     (fetch_fire),
        .pc_i             (pc),
        .jalr_executed_i  (jalr_done),
        .branch_taken_o   (branch_taken),
        .branch_addr_o    (branch_addr),
        .is_pred_branch_o (is_pred_branch),
        .wait_for_jalr_o  (wait_for_jalr)
    );

    if_id_reg u_if_id_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .fire_i  (fetch_fire),
        .stall_i (stall_i),
        .flush_i (redirect),       // wrong path out of decode
        .inst_i  (inst_i),
        .pc_i    (pc),
        .pred_i  (is_pred_branch),
        .inst_o  (id_inst_o),
        .pc_o    (id_pc_o),
        .pred_o  (id_pred),
        .valid_o (id_valid_o)
    );

    bru u_bru (
        .inst_i        (id_inst_o),
        .pc_i          (id_pc_o),
        .pred_i        (id_pred),
        .valid_i       (id_valid_o),
        .stall_i       (stall_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .jalr_done_o   (jalr_done)
    );

    assign fetch_pc_o    = pc;
    assign redirect_o    = redirect;
    assign redirect_pc_o = redirect_pc;

endmodule

/* tests/ifu_sva.sv */
// checks only the ifu_top ports and expects reserved branch funct3 codes to never appear
`timescale 1ns/100ps

module ifu_sva (
    input logic                     clk,
    input logic                     rst_n,
    input logic [ifu_pkg::XLEN-1:0] fetch_pc_o,
    input logic                     fetch_req_o,
    input logic [ifu_pkg::ILEN-1:0] inst_i,
    input logic                     inst_valid_i,
    input logic                     stall_i,
    input logic [ifu_pkg::XLEN-1:0] rs1_i,
    input logic [ifu_pkg::XLEN-1:0] rs2_i,
    input logic [ifu_pkg::ILEN-1:0] id_inst_o,
    input logic [ifu_pkg::XLEN-1:0] id_pc_o,
    input logic                     id_valid_o,
    input logic                     redirect_o,
    input logic [ifu_pkg::XLEN-1:0] redirect_pc_o
);
    import ifu_pkg::*;

    int unsigned     fail_cnt = 0;   // read by the testbench
    logic            fire;
    logic [XLEN-1:0] f_bimm;
    logic [XLEN-1:0] f_jimm;
    logic [XLEN-1:0] fetch_next;     // static rule for the fetched word
    logic            id_live;
    logic            id_br;
    logic            id_jalr;
    logic [XLEN-1:0] id_bimm;
    logic [XLEN-1:0] id_iimm;
    logic [XLEN-1:0] jalr_sum;
    logic            actual;
    logic [XLEN-1:0] id_target;
    logic [XLEN-1:0] next_q;
    logic [XLEN-1:0] fpc_q;
    logic [ILEN-1:0] inst_q;
    logic [XLEN-1:0] rdr_q;
    logic [ILEN-1:0] idi_q;
    logic            idv_q;
    logic            jalr_pend;

    assign fire   = inst_valid_i & fetch_req_o & ~redirect_o;
    assign f_bimm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign f_jimm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        fetch_next = fetch_pc_o + 32'd4;
        if (inst_i[6:0] == OPC_JAL) begin
            fetch_next = fetch_pc_o + f_jimm;
        end else if (inst_i[6:0] == OPC_BRANCH && f_bimm[XLEN-1]) begin
            fetch_next = fetch_pc_o + f_bimm;       // backward taken
        end
    end

    assign id_live  = id_valid_o & ~stall_i;
    assign id_br    = id_live & (id_inst_o[6:0] == OPC_BRANCH);
    assign id_jalr  = id_live & (id_inst_o[6:0] == OPC_JALR);
    assign id_bimm  = {{20{id_inst_o[31]}}, id_inst_o[7], id_inst_o[30:25],
                       id_inst_o[11:8], 1'b0};
    assign id_iimm  = {{20{id_inst_o[31]}}, id_inst_o[31:20]};
    assign jalr_sum = rs1_i + id_iimm;

    always_comb begin
        case (id_inst_o[14:12])
            F3_BEQ:  actual = (rs1_i == rs2_i);
            F3_BNE:  actual = (rs1_i != rs2_i);
            F3_BLT:  actual = ($signed(rs1_i) < $signed(rs2_i));
            F3_BGE:  actual = ($signed(rs1_i) >= $signed(rs2_i));
            F3_BLTU: actual = (rs1_i < rs2_i);
            F3_BGEU: actual = (rs1_i >= rs2_i);
            default: actual = 1'b0;
        endcase
    end

    assign id_target = actual ? (id_pc_o + id_bimm) : (id_pc_o + 32'd4);

    // one-cycle copies for the |=> checks
    always_ff @(posedge clk) begin
        next_q <= fetch_next;
        fpc_q  <= fetch_pc_o;
        inst_q <= inst_i;
        rdr_q  <= redirect_pc_o;
        idi_q  <= id_inst_o;
        idv_q  <= id_valid_o;
    end

    // jalr in flight between fetch and its resolve
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_pend <= 1'b0;
        end else if (fire && inst_i[6:0] == OPC_JALR) begin
            jalr_pend <= 1'b1;
        end else if (id_jalr) begin
            jalr_pend <= 1'b0;
        end
    end

    a_reset: assert property (@(posedge clk) !$past(rst_n) |->
        fetch_pc_o == RESET_PC && fetch_req_o && !id_valid_o && !redirect_o)
        else begin
            fail_cnt++;
            $error("front end not in its reset state");
        end

    a_next: assert property (@(posedge clk) disable iff (!rst_n)
        fire |=> fetch_pc_o == next_q)
        else begin
            fail_cnt++;
            $error("mismatch fetch_pc_o: exp %h got %h", $sampled(next_q),
                   $sampled(fetch_pc_o));
        end

    a_id_valid: assert property (@(posedge clk) disable iff (!rst_n)
        fire |=> id_valid_o)
        else begin
            fail_cnt++;
            $error("fetched instruction did not reach decode");
        end

    a_id_inst: assert property (@(posedge clk) disable iff (!rst_n)
        fire |=> id_inst_o == inst_q)
        else begin
            fail_cnt++;
            $error("mismatch id_inst_o: exp %h got %h", $sampled(inst_q),
                   $sampled(id_inst_o));
        end

    a_id_pc: assert property (@(posedge clk) disable iff (!rst_n)
        fire |=> id_pc_o == fpc_q)
        else begin
            fail_cnt++;
            $error("mismatch id_pc_o: exp %h got %h", $sampled(fpc_q), $sampled(id_pc_o));
        end

    a_mispredict: assert property (@(posedge clk) disable iff (!rst_n)
        id_br && (actual != id_bimm[XLEN-1]) |-> redirect_o)
        else begin
            fail_cnt++;
            $error("mispredicted branch did not redirect");
        end

    a_mis_target: assert property (@(posedge clk) disable iff (!rst_n)
        id_br && (actual != id_bimm[XLEN-1]) |-> redirect_pc_o == id_target)
        else begin
            fail_cnt++;
            $error("mismatch redirect_pc_o: exp %h got %h", $sampled(id_target),
                   $sampled(redirect_pc_o));
        end

    a_no_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        id_br && (actual == id_bimm[XLEN-1]) |-> !redirect_o)
        else begin
            fail_cnt++;
            $error("correctly predicted branch redirected");
        end

    a_jalr: assert property (@(posedge clk) disable iff (!rst_n)
        id_jalr |-> redirect_o)
        else begin
            fail_cnt++;
            $error("jalr in decode did not redirect");
        end

    a_jalr_target: assert property (@(posedge clk) disable iff (!rst_n)
        id_jalr |-> redirect_pc_o == {jalr_sum[XLEN-1:1], 1'b0})
        else begin
            fail_cnt++;
            $error("mismatch redirect_pc_o: exp %h got %h",
                   {$sampled(jalr_sum[XLEN-1:1]), 1'b0}, $sampled(redirect_pc_o));
        end

    a_recover: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |=> fetch_pc_o == rdr_q)
        else begin
            fail_cnt++;
            $error("mismatch fetch_pc_o: exp %h got %h", $sampled(rdr_q),
                   $sampled(fetch_pc_o));
        end

    a_flush: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_o |=> !id_valid_o)
        else begin
            fail_cnt++;
            $error("decode still valid after a redirect");
        end

    a_wait: assert property (@(posedge clk) disable iff (!rst_n)
        jalr_pend |-> !fetch_req_o)
        else begin
            fail_cnt++;
            $error("fetch requested while a jalr was pending");
        end

    a_resume: assert property (@(posedge clk) disable iff (!rst_n)
        id_jalr |=> fetch_req_o || stall_i)
        else begin
            fail_cnt++;
            $error("fetch did not resume after the jalr redirect");
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |=> fetch_pc_o == fpc_q && id_valid_o == idv_q
                    && (!idv_q || id_inst_o == idi_q))
        else begin
            fail_cnt++;
            $error("front end state moved during a stall");
        end

    a_stall_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        stall_i |-> !redirect_o)
        else begin
            fail_cnt++;
            $error("redirect raised during a stall");
        end

endmodule

/* tests/tb_ifu.sv */
// all result checks live in the bound ifu_sva and this module only drives and counts
`timescale 1ns/100ps

module tb_ifu;
    import ifu_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int BUDGET       = 300;    // per directed test
    localparam int RAND_BUDGET  = 3000;
    localparam int WD_CYCLES    = 5 * (RESET_CYCLES + BUDGET + 1)
                                + RESET_CYCLES + RAND_BUDGET + 200;  // margin

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] fetch_pc_o;
    logic            fetch_req_o;
    logic [ILEN-1:0] inst_i;
    logic            inst_valid_i;
    logic            stall_i;
    logic [XLEN-1:0] rs1_i;
    logic [XLEN-1:0] rs2_i;
    logic [ILEN-1:0] id_inst_o;
    logic [XLEN-1:0] id_pc_o;
    logic            id_valid_o;
    logic            redirect_o;
    logic [XLEN-1:0] redirect_pc_o;
    logic [ILEN-1:0] mem [256];           // word index is pc[9:2]
    logic            mem_rdy;
    int              seed;
    int              tests_run;
    int              tests_failed;

    ifu_top uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_req_o   (fetch_req_o),
        .inst_i        (inst_i),
        .inst_valid_i  (inst_valid_i),
        .stall_i       (stall_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .id_inst_o     (id_inst_o),
        .id_pc_o       (id_pc_o),
        .id_valid_o    (id_valid_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    bind ifu_top ifu_sva u_sva (.*);

    always #50 clk = ~clk;

    // combinational memory that answers only while requested
    assign inst_i       = mem[fetch_pc_o[9:2]];
    assign inst_valid_i = fetch_req_o & mem_rdy;

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [11:0] imm);
        return {imm, 5'd1, 3'b000, 5'd1, OPC_JALR};
    endfunction

    // addi x1, x0, word index so every word differs
    task automatic fill_alu;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {4'b0, 8'(i), 5'd0, 3'b000, 5'd1, 7'b001_0011};
        end
    endtask

    task automatic apply_reset;
        @(negedge clk);
        rst_n   = 1'b0;
        stall_i = 1'b0;
        mem_rdy = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // jal over, backward taken, jal, forward not taken (needs rs1 != rs2, bne taken)
    task automatic load_predict_prog;
        fill_alu();
        mem[0]  = enc_jal(21'h30);
        mem[12] = enc_branch(F3_BNE, -13'sd16);  // 0x30 back to 0x20
        mem[8]  = enc_jal(21'h20);               // 0x20 on to 0x40
        mem[16] = enc_branch(F3_BEQ, 13'h10);
        rs1_i   = 32'd5;
        rs2_i   = 32'd3;
    endtask

    // runs until fetch_pc_o hits stop_pc, or until fires_goal fetches when nonzero
    task automatic run_until(input string name, input logic [31:0] stop_pc, input int fires_goal,
                             input int budget, input int stall_thr, input bit rand_ops);
        int          cycles;
        int          fires;
        int          r;
        bit          reached;
        int unsigned err_base;
        int unsigned errs;
        err_base = uut.u_sva.fail_cnt;
        cycles   = 0;
        fires    = 0;
        reached  = 1'b0;
        while (!reached && cycles < budget) begin
            @(negedge clk);
            cycles++;
            if (fetch_req_o && inst_valid_i && !redirect_o) fires++;
            reached = (fires_goal == 0) ? (fetch_pc_o == stop_pc) : (fires >= fires_goal);
            r       = $random(seed);
            stall_i = (stall_thr > 0) && (int'(r[7:0]) < stall_thr);
            if (rand_ops) begin
                rs1_i   = 32'(r[15:13]);          // small values so equality happens
                rs2_i   = 32'(r[18:16]);
                mem_rdy = r[23:20] != 4'd0;       // occasional memory gap
            end
        end
        stall_i = 1'b0;
        mem_rdy = 1'b1;
        errs    = uut.u_sva.fail_cnt - err_base;
        tests_run++;
        if (!reached) begin
            $display("error: test %s did not reach its end within %0d cycles", name, budget);
        end
        if (!reached || errs != 0) tests_failed++;
        $display("test %s done after %0d cycles, %0d assertion failures", name, cycles, errs);
    endtask

    task automatic load_random_prog;
        logic [2:0] f3s [6];
        int         r;
        int         off;
        f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        fill_alu();
        for (int i = 0; i < 256; i++) begin
            r   = $random(seed);
            off = (int'(r[11:8]) + 1) * 4;        // 4 .. 64 bytes
            if (r[12]) off = -off;
            case (r[2:0])
                3'd0, 3'd1: mem[i] = enc_branch(f3s[int'(r[6:4]) % 6], 13'(off));
                3'd2:       mem[i] = enc_jal(21'(off));
                3'd3:       mem[i] = enc_jalr(12'(r[27:20]));
                default:    ;                     // keep the alu word
            endcase
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        stall_i      = 1'b0;
        rs1_i        = '0;
        rs2_i        = '0;
        mem_rdy      = 1'b1;
        seed         = 32'h232e_3977;
        tests_run    = 0;
        tests_failed = 0;
        fill_alu();

        apply_reset();
        run_until("sequential", 32'h40, 0, BUDGET, 0, 1'b0);

        load_predict_prog();
        apply_reset();
        run_until("predict", 32'h50, 0, BUDGET, 0, 1'b0);

        // every branch here goes against the static rule with rs1 == rs2
        fill_alu();
        mem[0] = enc_branch(F3_BNE, -13'sd8);
        mem[1] = enc_branch(F3_BGEU, 13'h20);    // 0x04 to 0x24
        mem[9] = enc_branch(F3_BLT, -13'sd4);
        rs1_i  = 32'd7;
        rs2_i  = 32'd7;
        apply_reset();
        run_until("mispredict", 32'h30, 0, BUDGET, 0, 1'b0);

        fill_alu();
        mem[2] = enc_jalr(12'h00f);               // 0x62 + 0xf is odd, lsb cleared to 0x70
        rs1_i  = 32'h62;
        apply_reset();
        run_until("jalr", 32'h78, 0, BUDGET, 0, 1'b0);

        load_predict_prog();
        apply_reset();
        run_until("stall", 32'h50, 0, BUDGET, 128, 1'b0);

        load_random_prog();
        apply_reset();
        run_until("random", 32'h0, 400, RAND_BUDGET, 64, 1'b1);

        $display("%0d tests, %0d failed, %0d assertion failures", tests_run, tests_failed,
                 uut.u_sva.fail_cnt);
        if (tests_failed == 0 && uut.u_sva.fail_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog sized from the test budgets
    initial begin
        #(WD_CYCLES * 100);
        $display("error: watchdog expired after %0d cycles", WD_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

/* sim.f */
logic/ifu_pkg.sv
logic/sbpu.sv
logic/pc_gen.sv
logic/if_id_reg.sv
logic/bru.sv
logic/ifu_top.sv
tests/ifu_sva.sv
tests/tb_ifu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ifu
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^\*\* PASS \*\*$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
